// File: axi_mem_defines.svh
`ifndef AXI_MEM_DEFINES_SVH
`define AXI_MEM_DEFINES_SVH

// bus widths
`define AXI_MEM_DATA_W 64
`define AXI_MEM_ADDR_W 32
`define AXI_MEM_ID_W 4
`define AXI_MEM_STRB_W (`AXI_MEM_DATA_W / 8)

// beats per burst is len + 1, so up to 8
`define AXI_MEM_LEN_W 3

// memory depth in 64-bit words
`define AXI_MEM_WORDS 256
// word index width, log2 of the depth
`define AXI_MEM_WADDR_W 8

// config port data width, also the refusal counter width
`define AXI_MEM_CFG_W 32

// window after reset, 2 KiB starting at the usual RAM base
`define AXI_MEM_BASE_RST 32'h8000_0000
`define AXI_MEM_LIMIT_RST (`AXI_MEM_BASE_RST + 32'd2048)

`endif

// File: axi_mem_pkg.sv
`include "axi_mem_defines.svh"

package axi_mem_pkg;

  // only two of the four codes are ever returned
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10
  } axi_resp_e;

  // ar and aw share this one
  typedef struct packed {
    logic [`AXI_MEM_ID_W-1:0]   id;
    logic [`AXI_MEM_ADDR_W-1:0] addr;
    logic [`AXI_MEM_LEN_W-1:0]  len;
  } axi_addr_req_t;

  // one read data beat
  typedef struct packed {
    logic [`AXI_MEM_ID_W-1:0]   id;
    logic [`AXI_MEM_DATA_W-1:0] data;
    axi_resp_e                  resp;
    logic                       last;
  } axi_r_beat_t;

  // one write data beat, strobe bit per byte lane
  typedef struct packed {
    logic [`AXI_MEM_DATA_W-1:0] data;
    logic [`AXI_MEM_STRB_W-1:0] strb;
    logic                       last;
  } axi_w_beat_t;

  typedef struct packed {
    logic [`AXI_MEM_ID_W-1:0] id;
    axi_resp_e                resp;
  } axi_b_resp_t;

  // limit is exclusive
  typedef struct packed {
    logic [`AXI_MEM_ADDR_W-1:0] base;
    logic [`AXI_MEM_ADDR_W-1:0] limit;
  } mem_window_t;

endpackage

// File: mem_array.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module mem_array (
  input  logic                       clock,
  input  logic                       rd_en_i,
  input  logic [`AXI_MEM_WADDR_W-1:0] rd_word_i,
  input  logic                       wr_en_i,
  input  logic [`AXI_MEM_WADDR_W-1:0] wr_word_i,
  input  logic [`AXI_MEM_DATA_W-1:0]  wr_data_i,
  input  logic [`AXI_MEM_STRB_W-1:0]  wr_strb_i,
  output logic [`AXI_MEM_DATA_W-1:0]  rd_data_o
);

  // word storage, contents undefined after power-up
  logic [`AXI_MEM_DATA_W-1:0] mem_q [`AXI_MEM_WORDS];

  // byte lanes with strobe low keep their old value
  always_ff @(posedge clock) begin
    if (wr_en_i) begin
      for (int b = 0; b < `AXI_MEM_STRB_W; b++) begin
        if (wr_strb_i[b]) begin
          mem_q[wr_word_i][8*b +: 8] <= wr_data_i[8*b +: 8];
        end
      end
    end
  end

  // registered read
  // same-word write in this cycle is not seen, old data comes back
  always_ff @(posedge clock) begin
    if (rd_en_i) begin
      rd_data_o <= mem_q[rd_word_i];
    end
  end

endmodule

// File: mem_window_regs.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module mem_window_regs (
  input  logic                      clock,
  input  logic                      reset_n,
  input  logic                      cfg_wr_i,
  input  logic                      cfg_rd_i,
  input  logic [1:0]                cfg_addr_i,
  input  logic [`AXI_MEM_CFG_W-1:0] cfg_wdata_i,
  input  logic                      rd_refused_i,
  input  logic                      wr_refused_i,
  output logic [`AXI_MEM_CFG_W-1:0] cfg_rdata_o,
  output axi_mem_pkg::mem_window_t  window_o
);
  import axi_mem_pkg::*;

  mem_window_t               window_q;
  logic [`AXI_MEM_CFG_W-1:0] rd_cnt_q;
  logic [`AXI_MEM_CFG_W-1:0] wr_cnt_q;
  logic [`AXI_MEM_CFG_W-1:0] rdata_mux;

  // clear wins over a pulse in the same cycle, otherwise stick at all ones
  function automatic logic [`AXI_MEM_CFG_W-1:0] count_next(
    input logic [`AXI_MEM_CFG_W-1:0] cnt,
    input logic                      pulse,
    input logic                      clear
  );
    if (clear) begin
      return '0;
    end
    if (pulse && !(&cnt)) begin
      return cnt + 1'b1;
    end
    return cnt;
  endfunction

  // reg map: 0 base, 1 limit, 2 read refusals, 3 write refusals
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      window_q.base  <= `AXI_MEM_BASE_RST;
      window_q.limit <= `AXI_MEM_LIMIT_RST;
      rd_cnt_q       <= '0;
      wr_cnt_q       <= '0;
    end else begin
      if (cfg_wr_i && cfg_addr_i == 2'd0) begin
        window_q.base <= cfg_wdata_i;
      end
      if (cfg_wr_i && cfg_addr_i == 2'd1) begin
        window_q.limit <= cfg_wdata_i;
      end
      rd_cnt_q <= count_next(rd_cnt_q, rd_refused_i, cfg_wr_i && cfg_addr_i == 2'd2);
      wr_cnt_q <= count_next(wr_cnt_q, wr_refused_i, cfg_wr_i && cfg_addr_i == 2'd3);
    end
  end

  always_comb begin
    case (cfg_addr_i)
      2'd0:    rdata_mux = window_q.base;
      2'd1:    rdata_mux = window_q.limit;
      2'd2:    rdata_mux = rd_cnt_q;
      default: rdata_mux = wr_cnt_q;
    endcase
  end

  // read-back lands one cycle after the strobe
  always_ff @(posedge clock) begin
    if (cfg_rd_i) begin
      cfg_rdata_o <= rdata_mux;
    end
  end

  assign window_o = window_q;

  // slave must keep its refusal pulses quiet while held in reset
  refusal_quiet_in_reset: assert property (
    @(posedge clock) !reset_n |-> !rd_refused_i && !wr_refused_i
  ) else $error("refusal pulse seen while reset is asserted");

endmodule

// File: axi_mem_slave.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_mem_slave (
  input  logic                        clock,
  input  logic                        reset_n,
  input  logic                        ar_valid_i,
  output logic                        ar_ready_o,
  input  axi_mem_pkg::axi_addr_req_t  ar_req_i,
  output logic                        r_valid_o,
  input  logic                        r_ready_i,
  output axi_mem_pkg::axi_r_beat_t    r_beat_o,
  input  logic                        aw_valid_i,
  output logic                        aw_ready_o,
  input  axi_mem_pkg::axi_addr_req_t  aw_req_i,
  input  logic                        w_valid_i,
  output logic                        w_ready_o,
  input  axi_mem_pkg::axi_w_beat_t    w_beat_i,
  output logic                        b_valid_o,
  input  logic                        b_ready_i,
  output axi_mem_pkg::axi_b_resp_t    b_resp_o,
  input  axi_mem_pkg::mem_window_t    window_i,
  output logic                        mem_rd_en_o,
  output logic [`AXI_MEM_WADDR_W-1:0] mem_rd_word_o,
  input  logic [`AXI_MEM_DATA_W-1:0]  mem_rd_data_i,
  output logic                        mem_wr_en_o,
  output logic [`AXI_MEM_WADDR_W-1:0] mem_wr_word_o,
  output logic [`AXI_MEM_DATA_W-1:0]  mem_wr_data_o,
  output logic [`AXI_MEM_STRB_W-1:0]  mem_wr_strb_o,
  output logic                        rd_refused_o,
  output logic                        wr_refused_o
);
  import axi_mem_pkg::*;

  // byte offset of the word index inside an address
  localparam int unsigned WORD_LSB = $clog2(`AXI_MEM_STRB_W);
  localparam logic [`AXI_MEM_ADDR_W-1:0] BEAT_STEP = `AXI_MEM_ADDR_W'(`AXI_MEM_STRB_W);

  typedef enum logic [1:0] {R_IDLE, R_FETCH, R_SEND} r_state_e;
  typedef enum logic [1:0] {W_IDLE, W_DATA, W_RESP} w_state_e;

  r_state_e      r_state_q;
  w_state_e      w_state_q;
  axi_addr_req_t rd_req_q;
  axi_addr_req_t wr_req_q;
  axi_r_beat_t   r_beat_q;
  axi_b_resp_t   b_resp_q;
  logic [`AXI_MEM_LEN_W-1:0] rd_cnt_q;
  logic [`AXI_MEM_LEN_W-1:0] wr_cnt_q;
  logic rd_phase_q;
  logic rd_err_q;
  logic wr_err_q;
  logic rd_refused_q;
  logic wr_refused_q;
  logic ar_hs, r_hs, aw_hs, w_hs, b_hs;
  logic rd_in_win;
  logic wr_in_win;
  logic wr_err_next;

  function automatic logic in_window(input logic [`AXI_MEM_ADDR_W-1:0] addr,
                                     input mem_window_t win);
    return (addr >= win.base) && (addr < win.limit);
  endfunction

  // offset from base in words wrapping at memory depth
  function automatic logic [`AXI_MEM_WADDR_W-1:0] word_of(
    input logic [`AXI_MEM_ADDR_W-1:0] addr,
    input mem_window_t                win
  );
    logic [`AXI_MEM_ADDR_W-1:0] off;
    off = addr - win.base;
    return off[WORD_LSB +: `AXI_MEM_WADDR_W];
  endfunction

  assign ar_hs = ar_valid_i && ar_ready_o;
  assign r_hs  = r_valid_o && r_ready_i;
  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;
  assign b_hs  = b_valid_o && b_ready_i;

  assign rd_in_win   = in_window(rd_req_q.addr, window_i);
  assign wr_in_win   = in_window(wr_req_q.addr, window_i);
  assign wr_err_next = wr_err_q || !wr_in_win;

  // read channel
  // fetch takes two cycles with the read issued in phase 0 and the data taken in phase 1
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      r_state_q    <= R_IDLE;
      rd_phase_q   <= 1'b0;
      rd_cnt_q     <= '0;
      rd_err_q     <= 1'b0;
      rd_refused_q <= 1'b0;
    end else begin
      rd_refused_q <= 1'b0;
      case (r_state_q)
        R_IDLE: begin
          if (ar_hs) begin
            r_state_q  <= R_FETCH;
            rd_phase_q <= 1'b0;
            rd_cnt_q   <= '0;
            rd_err_q   <= 1'b0;
          end
        end
        R_FETCH: begin
          rd_phase_q <= !rd_phase_q;
          if (rd_phase_q) begin
            r_state_q <= R_SEND;
            rd_err_q  <= rd_err_q || !rd_in_win;
          end
        end
        R_SEND: begin
          if (r_hs && r_beat_q.last) begin
            r_state_q    <= R_IDLE;
            // one pulse per burst however many beats missed
            rd_refused_q <= rd_err_q;
          end else if (r_hs) begin
            r_state_q <= R_FETCH;
            rd_cnt_q  <= rd_cnt_q + 1'b1;
          end
        end
        default: r_state_q <= R_IDLE;
      endcase
    end
  end

  // read payload with the address stepping one word per transferred beat
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      rd_req_q <= ar_req_i;
    end else if (r_hs) begin
      rd_req_q.addr <= rd_req_q.addr + BEAT_STEP;
    end
    if (r_state_q == R_FETCH && rd_phase_q) begin
      r_beat_q.id   <= rd_req_q.id;
      r_beat_q.data <= rd_in_win ? mem_rd_data_i : '0;
      r_beat_q.resp <= rd_in_win ? RESP_OKAY : RESP_SLVERR;
      r_beat_q.last <= (rd_cnt_q == rd_req_q.len);
    end
  end

  assign ar_ready_o    = (r_state_q == R_IDLE);
  assign r_valid_o     = (r_state_q == R_SEND);
  assign r_beat_o      = r_beat_q;
  assign mem_rd_en_o   = (r_state_q == R_FETCH) && !rd_phase_q;
  assign mem_rd_word_o = word_of(rd_req_q.addr, window_i);
  assign rd_refused_o  = rd_refused_q;

  // write channel
  always_ff @(posedge clock) begin
    if (!reset_n) begin
      w_state_q    <= W_IDLE;
      wr_cnt_q     <= '0;
      wr_err_q     <= 1'b0;
      wr_refused_q <= 1'b0;
    end else begin
      wr_refused_q <= 1'b0;
      case (w_state_q)
        W_IDLE: begin
          if (aw_hs) begin
            w_state_q <= W_DATA;
            wr_cnt_q  <= '0;
            wr_err_q  <= 1'b0;
          end
        end
        W_DATA: begin
          if (w_hs) begin
            wr_cnt_q <= wr_cnt_q + 1'b1;
            wr_err_q <= wr_err_next;
            if (w_beat_i.last) begin
              w_state_q    <= W_RESP;
              wr_refused_q <= wr_err_next;
            end
          end
        end
        W_RESP: begin
          if (b_hs) begin
            w_state_q <= W_IDLE;
          end
        end
        default: w_state_q <= W_IDLE;
      endcase
    end
  end

  // write payload and b response
  always_ff @(posedge clock) begin
    if (aw_hs) begin
      wr_req_q <= aw_req_i;
    end else if (w_hs) begin
      wr_req_q.addr <= wr_req_q.addr + BEAT_STEP;
    end
    if (w_hs && w_beat_i.last) begin
      b_resp_q.id   <= wr_req_q.id;
      b_resp_q.resp <= wr_err_next ? RESP_SLVERR : RESP_OKAY;
    end
  end

  assign aw_ready_o    = (w_state_q == W_IDLE);
  assign w_ready_o     = (w_state_q == W_DATA);
  assign b_valid_o     = (w_state_q == W_RESP);
  assign b_resp_o      = b_resp_q;
  // out-of-window beats are accepted but dropped here
  assign mem_wr_en_o   = w_hs && wr_in_win;
  assign mem_wr_word_o = word_of(wr_req_q.addr, window_i);
  assign mem_wr_data_o = w_beat_i.data;
  assign mem_wr_strb_o = w_beat_i.strb;
  assign wr_refused_o  = wr_refused_q;

  // stalled beat must not move
  r_beat_held: assert property (@(posedge clock) disable iff (!reset_n)
    r_valid_o && !r_ready_i |=> r_valid_o && $stable(r_beat_o)
  ) else $error("r beat changed while r_ready was low");

  // master's last flag against the latched aw length
  w_last_on_len: assert property (@(posedge clock) disable iff (!reset_n)
    w_hs |-> (w_beat_i.last == (wr_cnt_q == wr_req_q.len))
  ) else $error("w last does not line up with the burst length");

endmodule

// File: axi_mem_top.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module axi_mem_top (
  input  logic                       clock,
  input  logic                       reset_n,
  input  logic                       ar_valid_i,
  output logic                       ar_ready_o,
  input  axi_mem_pkg::axi_addr_req_t ar_req_i,
  output logic                       r_valid_o,
  input  logic                       r_ready_i,
  output axi_mem_pkg::axi_r_beat_t   r_beat_o,
  input  logic                       aw_valid_i,
  output logic                       aw_ready_o,
  input  axi_mem_pkg::axi_addr_req_t aw_req_i,
  input  logic                       w_valid_i,
  output logic                       w_ready_o,
  input  axi_mem_pkg::axi_w_beat_t   w_beat_i,
  output logic                       b_valid_o,
  input  logic                       b_ready_i,
  output axi_mem_pkg::axi_b_resp_t   b_resp_o,
  input  logic                       cfg_wr_i,
  input  logic                       cfg_rd_i,
  input  logic [1:0]                 cfg_addr_i,
  input  logic [`AXI_MEM_CFG_W-1:0]  cfg_wdata_i,
  output logic [`AXI_MEM_CFG_W-1:0]  cfg_rdata_o
);
  import axi_mem_pkg::*;

  // window level and refusal pulses between slave and config block
  mem_window_t window;
  logic        rd_refused;
  logic        wr_refused;

  // memory ports
  logic                        mem_rd_en;
  logic [`AXI_MEM_WADDR_W-1:0] mem_rd_word;
  logic [`AXI_MEM_DATA_W-1:0]  mem_rd_data;
  logic                        mem_wr_en;
  logic [`AXI_MEM_WADDR_W-1:0] mem_wr_word;
  logic [`AXI_MEM_DATA_W-1:0]  mem_wr_data;
  logic [`AXI_MEM_STRB_W-1:0]  mem_wr_strb;

  axi_mem_slave axi_mem_slave_inst (
    .clock         (clock),
    .reset_n       (reset_n),
    .ar_valid_i    (ar_valid_i),
    .ar_ready_o    (ar_ready_o),
    .ar_req_i      (ar_req_i),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .r_beat_o      (r_beat_o),
    .aw_valid_i    (aw_valid_i),
    .aw_ready_o    (aw_ready_o),
    .aw_req_i      (aw_req_i),
    .w_valid_i     (w_valid_i),
    .w_ready_o     (w_ready_o),
    .w_beat_i      (w_beat_i),
    .b_valid_o     (b_valid_o),
    .b_ready_i     (b_ready_i),
    .b_resp_o      (b_resp_o),
    .window_i      (window),
    .mem_rd_en_o   (mem_rd_en),
    .mem_rd_word_o (mem_rd_word),
    .mem_rd_data_i (mem_rd_data),
    .mem_wr_en_o   (mem_wr_en),
    .mem_wr_word_o (mem_wr_word),
    .mem_wr_data_o (mem_wr_data),
    .mem_wr_strb_o (mem_wr_strb),
    .rd_refused_o  (rd_refused),
    .wr_refused_o  (wr_refused)
  );

  mem_array mem_array_inst (
    .clock     (clock),
    .rd_en_i   (mem_rd_en),
    .rd_word_i (mem_rd_word),
    .wr_en_i   (mem_wr_en),
    .wr_word_i (mem_wr_word),
    .wr_data_i (mem_wr_data),
    .wr_strb_i (mem_wr_strb),
    .rd_data_o (mem_rd_data)
  );

  mem_window_regs mem_window_regs_inst (
    .clock        (clock),
    .reset_n      (reset_n),
    .cfg_wr_i     (cfg_wr_i),
    .cfg_rd_i     (cfg_rd_i),
    .cfg_addr_i   (cfg_addr_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .rd_refused_i (rd_refused),
    .wr_refused_i (wr_refused),
    .cfg_rdata_o  (cfg_rdata_o),
    .window_o     (window)
  );

endmodule

// File: tb_axi_mem_top.sv
`timescale 1ns/1ps
`include "axi_mem_defines.svh"

module tb_axi_mem_top;
  import axi_mem_pkg::*;

  // rough beat budget of the whole run at 20 cycles each plus slack
  localparam int PLANNED_BEATS = 450;
  localparam int TIMEOUT_CYCLES = PLANNED_BEATS * 20 + 1000;
  localparam int CH_AR = 0;
  localparam int CH_AW = 1;
  localparam int CH_W = 2;
  localparam int CH_B = 3;

  logic                      clock;
  logic                      reset_n;
  logic                      ar_valid;
  logic                      ar_ready;
  axi_addr_req_t             ar_req;
  logic                      r_valid;
  logic                      r_ready;
  axi_r_beat_t               r_beat;
  logic                      aw_valid;
  logic                      aw_ready;
  axi_addr_req_t             aw_req;
  logic                      w_valid;
  logic                      w_ready;
  axi_w_beat_t               w_beat;
  logic                      b_valid;
  logic                      b_ready;
  axi_b_resp_t               b_resp;
  logic                      cfg_wr;
  logic                      cfg_rd;
  logic [1:0]                cfg_addr;
  logic [`AXI_MEM_CFG_W-1:0] cfg_wdata;
  logic [`AXI_MEM_CFG_W-1:0] cfg_rdata;

  // reference model state
  logic [`AXI_MEM_DATA_W-1:0] ref_mem [`AXI_MEM_WORDS];
  logic [`AXI_MEM_ADDR_W-1:0] ref_base;
  logic [`AXI_MEM_ADDR_W-1:0] ref_limit;
  int                         ref_rd_refusals;
  int                         ref_wr_refusals;

  // predictions the assertions compare against
  axi_r_beat_t               exp_r;
  axi_b_resp_t               exp_b;
  logic                      cfg_check;
  logic [`AXI_MEM_CFG_W-1:0] exp_cfg;
  string                     test_name;
  int                        err_count;

  axi_mem_top axi_mem_top_inst (
    .clock       (clock),
    .reset_n     (reset_n),
    .ar_valid_i  (ar_valid),
    .ar_ready_o  (ar_ready),
    .ar_req_i    (ar_req),
    .r_valid_o   (r_valid),
    .r_ready_i   (r_ready),
    .r_beat_o    (r_beat),
    .aw_valid_i  (aw_valid),
    .aw_ready_o  (aw_ready),
    .aw_req_i    (aw_req),
    .w_valid_i   (w_valid),
    .w_ready_o   (w_ready),
    .w_beat_i    (w_beat),
    .b_valid_o   (b_valid),
    .b_ready_i   (b_ready),
    .b_resp_o    (b_resp),
    .cfg_wr_i    (cfg_wr),
    .cfg_rd_i    (cfg_rd),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata)
  );

  // 8 ns period
  always #4 clock = ~clock;

  function automatic logic addr_in_window(input logic [`AXI_MEM_ADDR_W-1:0] addr);
    return (addr >= ref_base) && (addr < ref_limit);
  endfunction

  // word offset from base wrapped at memory depth
  function automatic int word_index(input logic [`AXI_MEM_ADDR_W-1:0] addr);
    logic [`AXI_MEM_ADDR_W-1:0] off;
    off = addr - ref_base;
    return int'((off / 32'd8) % `AXI_MEM_WORDS);
  endfunction

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_word,
                                              input logic [63:0] new_word,
                                              input logic [7:0]  strb);
    logic [63:0] res;
    res = old_word;
    for (int b = 0; b < 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  // fill pattern built from the full byte address
  function automatic logic [63:0] fill_word(input logic [`AXI_MEM_ADDR_W-1:0] addr);
    return {~addr, addr};
  endfunction

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // ready is a flop output, so it is settled by the falling edge
  task automatic wait_transfer(input int chan);
    bit done;
    done = 1'b0;
    while (!done) begin
      @(negedge clock);
      case (chan)
        CH_AR:   done = ar_ready;
        CH_AW:   done = aw_ready;
        CH_W:    done = w_ready;
        default: done = b_valid;
      endcase
      next_cycle();
    end
  endtask

  task automatic write_burst(input logic [3:0] id, input logic [31:0] addr,
                             input logic [2:0] len, input bit rand_data,
                             input bit rand_strb);
    logic [31:0] beat_addr;
    logic        err;
    int          idx;
    err = 1'b0;
    aw_req.id = id;
    aw_req.addr = addr;
    aw_req.len = len;
    aw_valid = 1'b1;
    wait_transfer(CH_AW);
    aw_valid = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      beat_addr = addr + 32'(8 * k);
      w_beat.data = rand_data ? {$urandom, $urandom} : fill_word(beat_addr);
      w_beat.strb = rand_strb ? 8'($urandom) : 8'hff;
      w_beat.last = (k == int'(len));
      w_valid = 1'b1;
      wait_transfer(CH_W);
      // model update once the beat has moved
      if (addr_in_window(beat_addr)) begin
        idx = word_index(beat_addr);
        ref_mem[idx] = merge_bytes(ref_mem[idx], w_beat.data, w_beat.strb);
      end else begin
        err = 1'b1;
      end
    end
    w_valid = 1'b0;
    exp_b.id = id;
    exp_b.resp = err ? RESP_SLVERR : RESP_OKAY;
    if (err) begin
      ref_wr_refusals++;
    end
    // b_valid waits a few cycles for b_ready now and then
    repeat ($urandom_range(2)) next_cycle();
    b_ready = 1'b1;
    wait_transfer(CH_B);
    b_ready = 1'b0;
  endtask

  // stall drops r_ready on about a quarter of the cycles
  task automatic read_burst(input logic [3:0] id, input logic [31:0] addr,
                            input logic [2:0] len, input bit stall);
    logic [31:0] beat_addr;
    logic        err;
    bit          done;
    err = 1'b0;
    ar_req.id = id;
    ar_req.addr = addr;
    ar_req.len = len;
    ar_valid = 1'b1;
    wait_transfer(CH_AR);
    ar_valid = 1'b0;
    for (int k = 0; k <= int'(len); k++) begin
      beat_addr = addr + 32'(8 * k);
      exp_r.id = id;
      exp_r.last = (k == int'(len));
      if (addr_in_window(beat_addr)) begin
        exp_r.data = ref_mem[word_index(beat_addr)];
        exp_r.resp = RESP_OKAY;
      end else begin
        exp_r.data = '0;
        exp_r.resp = RESP_SLVERR;
        err = 1'b1;
      end
      done = 1'b0;
      while (!done) begin
        r_ready = stall ? ($urandom_range(3) != 0) : 1'b1;
        @(negedge clock);
        done = r_valid && r_ready;
        next_cycle();
      end
    end
    r_ready = 1'b0;
    if (err) begin
      ref_rd_refusals++;
    end
  endtask

  task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
    cfg_addr = addr;
    cfg_wdata = data;
    cfg_wr = 1'b1;
    next_cycle();
    cfg_wr = 1'b0;
    case (addr)
      2'd0:    ref_base = data;
      2'd1:    ref_limit = data;
      2'd2:    ref_rd_refusals = 0;
      default: ref_wr_refusals = 0;
    endcase
  endtask

  // idle first so a late refusal pulse has reached its counter
  task automatic cfg_read_check(input logic [1:0] addr, input logic [31:0] expected);
    repeat (3) next_cycle();
    cfg_addr = addr;
    cfg_rd = 1'b1;
    next_cycle();
    cfg_rd = 1'b0;
    exp_cfg = expected;
    cfg_check = 1'b1;
    next_cycle();
    cfg_check = 1'b0;
  endtask

  // value checks against the model
  r_beat_matches: assert property (@(posedge clock) disable iff (!reset_n)
    r_valid && r_ready |-> r_beat == exp_r
  ) else begin
    err_count++;
    $display("ERROR %s: r beat expected %h actual %h", test_name, $sampled(exp_r),
             $sampled(r_beat));
  end

  b_resp_matches: assert property (@(posedge clock) disable iff (!reset_n)
    b_valid && b_ready |-> b_resp == exp_b
  ) else begin
    err_count++;
    $display("ERROR %s: b response expected %h actual %h", test_name, $sampled(exp_b),
             $sampled(b_resp));
  end

  cfg_rdata_matches: assert property (@(posedge clock) disable iff (!reset_n)
    cfg_check |-> cfg_rdata == exp_cfg
  ) else begin
    err_count++;
    $display("ERROR %s: config read expected %h actual %h", test_name, $sampled(exp_cfg),
             $sampled(cfg_rdata));
  end

  // protocol rules
  idle_after_reset: assert property (@(posedge clock)
    $rose(reset_n) |-> ar_ready && aw_ready && !w_ready && !r_valid && !b_valid
  ) else begin
    err_count++;
    $display("channels were not idle when reset was released");
  end

  r_held_while_stalled: assert property (@(posedge clock) disable iff (!reset_n)
    r_valid && !r_ready |=> r_valid && $stable(r_beat)
  ) else begin
    err_count++;
    $display("r beat dropped or changed while r_ready was low");
  end

  b_held_while_stalled: assert property (@(posedge clock) disable iff (!reset_n)
    b_valid && !b_ready |=> b_valid && $stable(b_resp)
  ) else begin
    err_count++;
    $display("b response dropped or changed while b_ready was low");
  end

  ar_blocked_during_read: assert property (@(posedge clock) disable iff (!reset_n)
    r_valid |-> !ar_ready
  ) else begin
    err_count++;
    $display("ar_ready was high while a read burst was still being sent");
  end

  w_ready_after_aw: assert property (@(posedge clock) disable iff (!reset_n)
    aw_valid && aw_ready |=> w_ready
  ) else begin
    err_count++;
    $display("w_ready did not rise the cycle after the aw handshake");
  end

  b_after_last_w: assert property (@(posedge clock) disable iff (!reset_n)
    w_valid && w_ready && w_beat.last |=> b_valid
  ) else begin
    err_count++;
    $display("b_valid did not rise the cycle after the last w beat");
  end

  // run-length limit
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clock);
    $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("summary: %0d errors", err_count);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    logic [31:0] addr;
    logic [31:0] new_base;
    void'($urandom(32'h7d8));
    clock = 1'b0;
    reset_n = 1'b0;
    ar_valid = 1'b0;
    ar_req = '0;
    r_ready = 1'b0;
    aw_valid = 1'b0;
    aw_req = '0;
    w_valid = 1'b0;
    w_beat = '0;
    b_ready = 1'b0;
    cfg_wr = 1'b0;
    cfg_rd = 1'b0;
    cfg_addr = 2'd0;
    cfg_wdata = '0;
    exp_r = '0;
    exp_b = '0;
    cfg_check = 1'b0;
    exp_cfg = '0;
    err_count = 0;
    ref_base = `AXI_MEM_BASE_RST;
    ref_limit = `AXI_MEM_LIMIT_RST;
    ref_rd_refusals = 0;
    ref_wr_refusals = 0;
    test_name = "reset";
    repeat (5) next_cycle();
    reset_n = 1'b1;
    next_cycle();

    // every word gets a known value first
    test_name = "fill";
    for (int w = 0; w < `AXI_MEM_WORDS / 8; w++) begin
      write_burst(4'(w), ref_base + 32'(64 * w), 3'd7, 1'b0, 1'b0);
    end

    test_name = "single_beat";
    write_burst(4'h3, ref_base + 32'h100, 3'd0, 1'b1, 1'b0);
    read_burst(4'hc, ref_base + 32'h100, 3'd0, 1'b0);

    test_name = "partial_strobe";
    repeat (4) begin
      addr = ref_base + 32'(8 * $urandom_range(255));
      write_burst(4'($urandom), addr, 3'd0, 1'b1, 1'b1);
      read_burst(4'($urandom), addr, 3'd0, 1'b0);
    end

    test_name = "burst_len";
    for (int i = 0; i < 8; i++) begin
      addr = ref_base + 32'(8 * $urandom_range(248));
      write_burst(4'($urandom), addr, 3'(i), 1'b1, 1'b1);
      read_burst(4'($urandom), addr, 3'(i), 1'b0);
    end
    // both channels at once on disjoint words
    fork
      write_burst(4'h5, ref_base + 32'(8 * 200), 3'd7, 1'b1, 1'b1);
      read_burst(4'ha, ref_base, 3'd7, 1'b0);
    join

    test_name = "r_backpressure";
    repeat (6) begin
      read_burst(4'($urandom), ref_base + 32'(8 * $urandom_range(248)), 3'd7, 1'b1);
    end

    test_name = "window_refusal";
    cfg_read_check(2'd2, 32'd0);
    cfg_read_check(2'd3, 32'd0);
    // last two beats cross the limit and alias words 0 and 1
    write_burst(4'h7, ref_limit - 32'd16, 3'd3, 1'b1, 1'b0);
    read_burst(4'h1, ref_base, 3'd1, 1'b0);
    read_burst(4'h2, ref_limit - 32'd8, 3'd2, 1'b0);
    read_burst(4'h4, ref_base - 32'd8, 3'd0, 1'b0);
    cfg_read_check(2'd2, 32'(ref_rd_refusals));
    cfg_read_check(2'd3, 32'(ref_wr_refusals));
    cfg_write(2'd2, 32'd0);
    cfg_write(2'd3, 32'd0);
    cfg_read_check(2'd2, 32'd0);
    cfg_read_check(2'd3, 32'd0);

    test_name = "window_move";
    new_base = 32'h4000_0000;
    cfg_write(2'd0, new_base);
    cfg_write(2'd1, new_base + 32'd2048);
    cfg_read_check(2'd0, new_base);
    cfg_read_check(2'd1, new_base + 32'd2048);
    read_burst(4'h6, new_base, 3'd7, 1'b1);
    read_burst(4'h8, new_base + 32'(8 * 100), 3'd3, 1'b0);
    read_burst(4'h9, `AXI_MEM_BASE_RST, 3'd0, 1'b0);
    write_burst(4'hb, new_base + 32'h40, 3'd1, 1'b1, 1'b1);
    read_burst(4'hd, new_base + 32'h40, 3'd1, 1'b0);
    cfg_read_check(2'd2, 32'(ref_rd_refusals));

    repeat (4) next_cycle();
    $display("summary: %0d errors", err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: axi_mem_top.f
+incdir+.
axi_mem_pkg.sv
mem_array.sv
mem_window_regs.sv
axi_mem_slave.sv
axi_mem_top.sv
tb_axi_mem_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the axi_mem_top testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module tb_axi_mem_top -f axi_mem_top.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_axi_mem_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see $LOG"
exit 1
